/* tests/channel_sum_golden.txt */
# I <pixel, 16-bit hex>: input pixel, channel-major, pixel-major within a plane
# O <pixel index> <sum, 32-bit hex>: expected output beat of the group above
I 0001
I 0002
I 0003
I 0004
I 000A
I FFEC
I 001E
I FFD8
I 0064
I 00C8
I FED4
I 0190
I FC18
I 03E8
I FFFB
I 0005
O 0 FFFFFC87
O 1 0000049E
O 2 FFFFFEF0
O 3 00000171
I 7FFF
I 8000
I 7FFF
I 0000
I 7FFF
I 8000
I 8000
I FFFF
I 7FFF
I 8000
I 7FFF
I 0001
I 7FFF
I 8000
I 8000
I FFFF
O 0 0001FFFC
O 1 FFFE0000
O 2 FFFFFFFE
O 3 FFFFFFFF

/* sim.f */
+incdir+include
logic/channel_sum_pkg.sv
logic/beat_receiver.sv
logic/plane_delay_line.sv
logic/channel_adder_tree.sv
logic/sum_sender.sv
logic/channel_sum_top.sv
tests/channel_sum_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the channel sum testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module channel_sum_tb \
  -f sim.f -o channel_sum_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/channel_sum_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1

/* tests/channel_sum_tb.sv */
`timescale 1ns/100ps
`include "channel_sum_consts.svh"

module channel_sum_tb;
  import channel_sum_pkg::*;

  localparam int PLANE      = `CS_PLANE_PIXELS;
  localparam int GROUP_IN   = `CS_CHANNELS * `CS_PLANE_PIXELS;
  localparam int FIRST_SUM  = (`CS_CHANNELS - 1) * `CS_PLANE_PIXELS + 1;
  localparam int LINE_TICKS = 100;

  logic      clk;
  logic      reset;
  logic      in_valid;
  pixel_t    in_data;
  logic      in_credit;
  logic      out_valid;
  sum_beat_t out_beat;
  logic      out_credit;

  pixel_t      in_list[$];
  sum_beat_t   exp_list[$];
  int          golden_lines;
  int          errors;
  int          checks;
  int          up_credits;
  int          dn_credits;
  int          dn_owed;
  int          accepted;
  int          credit_pulses;
  logic [31:0] lcg_state;
  int          watchdog_ns = 0;

  channel_sum_top channel_sum_top_inst (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_beat   (out_beat),
    .out_credit (out_credit)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %t: %s is %h, expected %h", $realtime, name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("failure at %t: %s", $realtime, what);
  endtask

  task automatic finish_test(input int num, input string name, input int errors_before);
    $display("test %0d %s: %0d errors", num, name, errors - errors_before);
  endtask

  task automatic read_golden();
    int          fd;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    sum_beat_t   beat;
    fd = $fopen("tests/channel_sum_golden.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open tests/channel_sum_golden.txt");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      golden_lines++;
      if (line.getc(0) == "#" || line.getc(0) == "\n") begin
        continue;
      end
      if (line.getc(0) == "I" && $sscanf(line, "I %h", a) == 1) begin
        in_list.push_back(pixel_t'(a));
      end else if (line.getc(0) == "O" && $sscanf(line, "O %d %h", b, a) == 2) begin
        beat.sum   = sum_t'(a);
        beat.index = pix_idx_t'(b);
        exp_list.push_back(beat);
      end else begin
        report_failure("malformed line in the golden file");
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One stretch of traffic, stepped on falling edges until fully drained
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_phase(input int first_in, input int n_in, input int first_out,
                           input int n_out, input bit random_credits);
    int next_in;
    int got;
    next_in = first_in;
    got = 0;
    while (next_in < first_in + n_in || got < n_out || dn_owed > 0 || out_credit) begin
      @(negedge clk);
      // Outputs settled at the last rising edge
      if (in_credit) begin
        up_credits++;
        credit_pulses++;
        if (up_credits > `CS_IN_FIFO_DEPTH) begin
          report_failure("upstream credit counter went above the FIFO depth");
        end
      end
      if (out_valid) begin
        if (dn_credits == 0) begin
          report_failure("output beat sent while no downstream credit was held");
        end else begin
          dn_credits--;
        end
        dn_owed++;
        if (next_in - first_in < FIRST_SUM) begin
          report_failure("output beat before a full channel group was sent");
        end
        if (got < n_out) begin
          check_value("out_beat.index", 32'(out_beat.index),
                      32'(exp_list[first_out + got].index));
          check_value("out_beat.sum", out_beat.sum, exp_list[first_out + got].sum);
        end else begin
          report_failure("more output beats than expected");
        end
        got++;
      end
      // Credit driven last falling edge was taken at the rising edge
      if (out_credit) begin
        dn_credits++;
      end
      out_credit = 1'b0;
      if (dn_owed > 0) begin
        if (random_credits) begin
          lcg_state = lcg_next(lcg_state);
        end
        if (!random_credits || lcg_state[30:29] == 2'b00) begin
          out_credit = 1'b1;
          dn_owed--;
        end
      end
      in_valid = 1'b0;
      if (next_in < first_in + n_in && up_credits > 0) begin
        in_valid = 1'b1;
        in_data  = in_list[next_in];
        up_credits--;
        accepted++;
        next_in++;
      end
    end
  endtask

  initial begin
    int mark;
    $timeformat(-9, 1, " ns", 0);
    reset         = 1'b1;
    in_valid      = 1'b0;
    in_data       = '0;
    out_credit    = 1'b0;
    lcg_state     = 32'd2;
    errors        = 0;
    checks        = 0;
    golden_lines  = 0;
    accepted      = 0;
    credit_pulses = 0;
    dn_owed       = 0;
    up_credits    = `CS_IN_FIFO_DEPTH;
    dn_credits    = `CS_OUT_CREDITS;
    read_golden();
    watchdog_ns = (golden_lines + 10) * LINE_TICKS * 4;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    if (in_list.size() != 2 * GROUP_IN || exp_list.size() != 2 * PLANE) begin
      report_failure("golden file does not hold two full channel groups");
    end else begin
      mark = errors;
      repeat (4) begin
        @(negedge clk);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("in_credit", 32'(in_credit), 32'd0);
      end
      finish_test(1, "reset state", mark);

      mark = errors;
      run_phase(0, GROUP_IN, 0, PLANE, 1'b0);
      finish_test(2, "group 1 prompt credits", mark);

      mark = errors;
      run_phase(GROUP_IN, GROUP_IN, PLANE, PLANE, 1'b0);
      finish_test(3, "group 2 extreme values", mark);

      mark = errors;
      run_phase(0, 2 * GROUP_IN, 0, 2 * PLANE, 1'b1);
      finish_test(4, "random downstream credits", mark);

      mark = errors;
      check_value("in_credit pulses", 32'(credit_pulses), 32'(accepted));
      check_value("upstream credits", 32'(up_credits), 32'(`CS_IN_FIFO_DEPTH));
      finish_test(5, "upstream credit balance", mark);
    end

    $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog, limit scales with the golden file length
  initial begin
    wait (watchdog_ns > 0);
    #(watchdog_ns);
    $display("timeout: the run did not finish within %0d ns", watchdog_ns);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* logic/channel_sum_top.sv */
`timescale 1ns/100ps

module channel_sum_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       in_valid,
  input  channel_sum_pkg::pixel_t    in_data,
  output logic                       in_credit,
  output logic                       out_valid,
  output channel_sum_pkg::sum_beat_t out_beat,
  input  logic                       out_credit
);
  import channel_sum_pkg::*;

  logic           slot_free;
  logic           issue_valid;
  channel_pixel_t issue_pixel;
  logic           vec_valid;
  channel_vec_t   vec;
  logic           sum_valid;
  sum_beat_t      sum_beat;

  beat_receiver beat_receiver_inst (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .in_credit   (in_credit),
    .slot_free   (slot_free),
    .issue_valid (issue_valid),
    .issue_pixel (issue_pixel)
  );

  plane_delay_line plane_delay_line_inst (
    .clk         (clk),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue_pixel (issue_pixel),
    .vec_valid   (vec_valid),
    .vec         (vec)
  );

  channel_adder_tree channel_adder_tree_inst (
    .clk       (clk),
    .reset     (reset),
    .vec_valid (vec_valid),
    .vec       (vec),
    .sum_valid (sum_valid),
    .sum_beat  (sum_beat)
  );

  // Each last-channel issue books an output slot
  sum_sender sum_sender_inst (
    .clk        (clk),
    .reset      (reset),
    .reserve    (issue_valid && issue_pixel.last_channel),
    .sum_valid  (sum_valid),
    .sum_beat   (sum_beat),
    .slot_free  (slot_free),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_beat   (out_beat)
  );

endmodule

/* logic/sum_sender.sv */
`timescale 1ns/100ps
`include "channel_sum_consts.svh"

module sum_sender (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       reserve,
  input  logic                       sum_valid,
  input  channel_sum_pkg::sum_beat_t sum_beat,
  output logic                       slot_free,
  input  logic                       out_credit,
  output logic                       out_valid,
  output channel_sum_pkg::sum_beat_t out_beat
);
  import channel_sum_pkg::*;

  localparam int DEPTH = `CS_OUT_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int CRD_W = $clog2(`CS_OUT_CREDITS + 1);

  sum_beat_t        fifo_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fifo_cnt;
  logic [CNT_W-1:0] resv_cnt;
  logic [CNT_W:0]   pending;
  logic [CRD_W-1:0] credit_cnt;
  logic             send;

  // Stored sums plus sums still inside the delay line and tree
  assign pending   = fifo_cnt + resv_cnt;
  assign slot_free = (pending < (CNT_W + 1)'(DEPTH));
  assign send      = (fifo_cnt != '0) && (credit_cnt != '0);

  always_ff @(posedge clk) begin
    if (sum_valid) begin
      fifo_mem[wr_ptr] <= sum_beat;
    end
    if (send) begin
      out_beat <= fifo_mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_cnt   <= '0;
      resv_cnt   <= '0;
      credit_cnt <= CRD_W'(`CS_OUT_CREDITS);
      out_valid  <= 1'b0;
    end else begin
      if (sum_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({sum_valid, send})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
      // A written sum releases the oldest reservation
      case ({reserve, sum_valid})
        2'b10:   resv_cnt <= resv_cnt + 1'b1;
        2'b01:   resv_cnt <= resv_cnt - 1'b1;
        default: resv_cnt <= resv_cnt;
      endcase
      case ({out_credit, send})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
      out_valid <= send;
    end
  end

endmodule

/* logic/channel_adder_tree.sv */
`timescale 1ns/100ps
`include "channel_sum_consts.svh"

module channel_adder_tree (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          vec_valid,
  input  channel_sum_pkg::channel_vec_t vec,
  output logic                          sum_valid,
  output channel_sum_pkg::sum_beat_t    sum_beat
);
  import channel_sum_pkg::*;

  localparam int CHANNELS = `CS_CHANNELS;
  localparam int LEVELS   = $clog2(CHANNELS);

  // Registered results of each level, level l keeps CHANNELS >> (l+1) sums
  sum_t     stage_sum   [LEVELS][CHANNELS];
  logic     stage_valid [LEVELS];
  pix_idx_t stage_index [LEVELS];

  for (genvar l = 0; l < LEVELS; l++) begin : g_level
    localparam int HALF = CHANNELS >> (l + 1);

    sum_t     src_sum [2*HALF];
    logic     src_valid;
    pix_idx_t src_index;

    if (l == 0) begin : g_from_vec
      assign src_valid = vec_valid;
      assign src_index = vec.index;
      // Sign extension to the sum width
      for (genvar i = 0; i < 2 * HALF; i++) begin : g_ext
        assign src_sum[i] = sum_t'($signed(vec.pixels[i]));
      end
    end else begin : g_from_stage
      assign src_valid = stage_valid[l-1];
      assign src_index = stage_index[l-1];
      for (genvar i = 0; i < 2 * HALF; i++) begin : g_fwd
        assign src_sum[i] = stage_sum[l-1][i];
      end
    end

    always_ff @(posedge clk) begin
      if (reset) begin
        stage_valid[l] <= 1'b0;
      end else begin
        stage_valid[l] <= src_valid;
      end
    end

    always_ff @(posedge clk) begin
      stage_index[l] <= src_index;
    end

    // Pair i with i+half, wraps at the sum width
    for (genvar i = 0; i < HALF; i++) begin : g_add
      always_ff @(posedge clk) begin
        stage_sum[l][i] <= src_sum[i] + src_sum[i+HALF];
      end
    end
  end

  assign sum_valid      = stage_valid[LEVELS-1];
  assign sum_beat.sum   = stage_sum[LEVELS-1][0];
  assign sum_beat.index = stage_index[LEVELS-1];

endmodule

/* logic/plane_delay_line.sv */
`timescale 1ns/100ps
`include "channel_sum_consts.svh"

module plane_delay_line (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            issue_valid,
  input  channel_sum_pkg::channel_pixel_t issue_pixel,
  output logic                            vec_valid,
  output channel_sum_pkg::channel_vec_t   vec
);
  import channel_sum_pkg::*;

  localparam int CHANNELS = `CS_CHANNELS;
  localparam int PIXELS   = `CS_PLANE_PIXELS;
  localparam int TAPS     = (CHANNELS - 1) * PIXELS;

  // taps[0] holds the pixel issued one beat ago
  pixel_t taps [TAPS];
  logic   last_issue;

  assign last_issue = issue_valid && issue_pixel.last_channel;

  ////////////////////////////////////////////////////////////////////////////
  // Plane-length shift chain, steps once per issued pixel
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      taps[0] <= issue_pixel.pixel;
      for (int k = 1; k < TAPS; k++) begin
        taps[k] <= taps[k-1];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Channel vector capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      vec_valid <= 1'b0;
    end else begin
      vec_valid <= last_issue;
    end
  end

  // Channel c sits (CHANNELS-1-c) planes behind the current pixel
  always_ff @(posedge clk) begin
    if (last_issue) begin
      vec.pixels[CHANNELS-1] <= issue_pixel.pixel;
      for (int c = 0; c < CHANNELS - 1; c++) begin
        vec.pixels[c] <= taps[(CHANNELS - 1 - c) * PIXELS - 1];
      end
      vec.index <= issue_pixel.index;
    end
  end

endmodule

/* logic/beat_receiver.sv */
`timescale 1ns/100ps
`include "channel_sum_consts.svh"

module beat_receiver (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            in_valid,
  input  channel_sum_pkg::pixel_t         in_data,
  output logic                            in_credit,
  input  logic                            slot_free,
  output logic                            issue_valid,
  output channel_sum_pkg::channel_pixel_t issue_pixel
);
  import channel_sum_pkg::*;

  localparam int DEPTH  = `CS_IN_FIFO_DEPTH;
  localparam int PTR_W  = $clog2(DEPTH);
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int CHAN_W = $clog2(`CS_CHANNELS);

  pixel_t            fifo_mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  fifo_cnt;
  pix_idx_t          pix_idx;
  logic [CHAN_W-1:0] chan_idx;
  logic              head_last;

  ////////////////////////////////////////////////////////////////////////////
  // Issue control
  ////////////////////////////////////////////////////////////////////////////

  assign head_last = (chan_idx == CHAN_W'(`CS_CHANNELS - 1));

  // Only a last-channel pixel makes a sum, so only it needs output space
  assign issue_valid = (fifo_cnt != '0) && (!head_last || slot_free);

  assign issue_pixel.pixel        = fifo_mem[rd_ptr];
  assign issue_pixel.index        = pix_idx;
  assign issue_pixel.last_channel = head_last;

  ////////////////////////////////////////////////////////////////////////////
  // Input FIFO
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (in_valid) begin
      fifo_mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fifo_cnt  <= '0;
      in_credit <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (issue_valid) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({in_valid, issue_valid})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
      // One credit back per popped entry
      in_credit <= issue_valid;
    end
  end

  // Position of the head pixel, pixel-major within a plane
  always_ff @(posedge clk) begin
    if (reset) begin
      pix_idx  <= '0;
      chan_idx <= '0;
    end else if (issue_valid) begin
      if (pix_idx == pix_idx_t'(`CS_PLANE_PIXELS - 1)) begin
        pix_idx  <= '0;
        chan_idx <= head_last ? '0 : chan_idx + 1'b1;
      end else begin
        pix_idx <= pix_idx + 1'b1;
      end
    end
  end

endmodule

/* logic/channel_sum_pkg.sv */
`include "channel_sum_consts.svh"

package channel_sum_pkg;

  typedef logic signed [`CS_DATA_WIDTH-1:0] pixel_t;
  typedef logic signed [`CS_SUM_WIDTH-1:0] sum_t;

  // Position of a pixel inside its plane
  typedef logic [$clog2(`CS_PLANE_PIXELS)-1:0] pix_idx_t;

  // Receiver to delay line
  typedef struct packed {
    pixel_t   pixel;
    pix_idx_t index;
    logic     last_channel;
  } channel_pixel_t;

  // Co-located pixels of all channels, channel 0 in the lowest slot
  typedef struct packed {
    pixel_t [`CS_CHANNELS-1:0] pixels;
    pix_idx_t                  index;
  } channel_vec_t;

  typedef struct packed {
    sum_t     sum;
    pix_idx_t index;
  } sum_beat_t;

endpackage

/* include/channel_sum_consts.svh */
`ifndef CHANNEL_SUM_CONSTS_SVH
`define CHANNEL_SUM_CONSTS_SVH

// Pixel and sum word widths
`define CS_DATA_WIDTH 16
`define CS_SUM_WIDTH 32

// Planes per accumulation group, kept a power of two for the adder tree
`define CS_CHANNELS 4

// Pixels in one feature-map plane
`define CS_PLANE_PIXELS 4

// Input FIFO depth doubles as the upstream credit count
`define CS_IN_FIFO_DEPTH 4
`define CS_OUT_FIFO_DEPTH 4

// Credits granted by downstream at reset
`define CS_OUT_CREDITS 2

`endif
